//--- miner_settings.svh
`ifndef MINER_SETTINGS_SVH
`define MINER_SETTINGS_SVH

// UART bit time in clock cycles, kept short for simulation
`define CLOCKS_PER_BIT 8

// Width of the bit-time counters in the receiver and transmitter
`define BIT_TIMER_WIDTH 8

// Block header length in bytes
`define HEADER_BYTES 80

// SHA-256 rounds per compression
`define SHA_ROUNDS 64

`endif

//--- miner_pkg.sv
package miner_pkg;

    // Search control states
    typedef enum logic [2:0] {
        Load,
        Block1,
        Block2,
        Check,
        Send,
        Idle
    } minerState;

    // Shared by the receiver and the transmitter
    typedef enum logic [1:0] {
        UartIdle,
        UartStart,
        UartData,
        UartStop
    } uartState;

    // SHA-256 round constants K0..K63
    localparam logic [31:0] roundTable [64] = '{
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
        32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
        32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
        32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
        32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
        32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
        32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
        32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
        32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
        32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
        32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
        32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
        32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
        32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
        32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
        32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
    };

    // H0..H7, H0 in the top word
    localparam logic [255:0] initialHash = {
        32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
        32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
    };

    function automatic logic [31:0] roundConstant(input logic [5:0] index);
        return roundTable[index];
    endfunction

endpackage

//--- uartReceiver.sv
`include "miner_settings.svh"

module uartReceiver import miner_pkg::*; (
    input  logic       clock,
    input  logic       rstN,
    input  logic       rxd,
    output logic [7:0] rxByte,
    output logic       rxValid
);

    logic [1:0] rxSync;
    logic       rxLine;
    uartState   state;
    logic [`BIT_TIMER_WIDTH-1:0] bitTimer;
    logic [2:0] bitIndex;
    logic [7:0] shiftReg;
    logic       halfBit;
    logic       fullBit;

    // Synchronized line, idles high
    assign rxLine = rxSync[1];

    // Half a bit lines the sampling up with mid-bit
    assign halfBit = bitTimer == `BIT_TIMER_WIDTH'(`CLOCKS_PER_BIT / 2 - 1);
    assign fullBit = bitTimer == `BIT_TIMER_WIDTH'(`CLOCKS_PER_BIT - 1);

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            rxSync   <= 2'b11;
            state    <= UartIdle;
            bitTimer <= '0;
            bitIndex <= '0;
            rxValid  <= 1'b0;
        end else begin
            rxSync  <= {rxSync[0], rxd};
            rxValid <= 1'b0;
            bitTimer <= bitTimer + 1'b1;
            case (state)
                UartIdle: begin
                    bitTimer <= '0;
                    // Falling edge marks a start bit
                    if (!rxLine) begin
                        state <= UartStart;
                    end
                end
                UartStart: begin
                    if (halfBit) begin
                        bitTimer <= '0;
                        bitIndex <= '0;
                        // Glitch shorter than half a bit is ignored
                        state    <= rxLine ? UartIdle : UartData;
                    end
                end
                UartData: begin
                    if (fullBit) begin
                        bitTimer <= '0;
                        bitIndex <= bitIndex + 1'b1;
                        if (bitIndex == 3'd7) begin
                            state <= UartStop;
                        end
                    end
                end
                UartStop: begin
                    if (fullBit) begin
                        bitTimer <= '0;
                        state    <= UartIdle;
                        // Low stop bit is a framing error, byte dropped
                        rxValid  <= rxLine;
                    end
                end
                default: state <= UartIdle;
            endcase
        end
    end

    // Data arrives LSB first
    always_ff @(posedge clock) begin
        if (state == UartData && fullBit) begin
            shiftReg <= {rxLine, shiftReg[7:1]};
        end
        if (state == UartStop && fullBit && rxLine) begin
            rxByte <= shiftReg;
        end
    end

endmodule

//--- uartTransmitter.sv
`include "miner_settings.svh"

module uartTransmitter import miner_pkg::*; (
    input  logic       clock,
    input  logic       rstN,
    input  logic       txStart,
    input  logic [7:0] txByte,
    output logic       txd,
    output logic       txBusy
);

    uartState   state;
    logic [`BIT_TIMER_WIDTH-1:0] bitTimer;
    logic [2:0] bitIndex;
    logic [7:0] shiftReg;
    logic       bitEnd;

    assign bitEnd = bitTimer == `BIT_TIMER_WIDTH'(`CLOCKS_PER_BIT - 1);
    // Busy through the whole frame, start strobes meanwhile are dropped
    assign txBusy = state != UartIdle;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            state    <= UartIdle;
            bitTimer <= '0;
            bitIndex <= '0;
            txd      <= 1'b1;
        end else begin
            bitTimer <= bitEnd ? '0 : bitTimer + 1'b1;
            case (state)
                UartIdle: begin
                    bitTimer <= '0;
                    txd      <= 1'b1;
                    if (txStart) begin
                        state <= UartStart;
                        txd   <= 1'b0;
                    end
                end
                UartStart: begin
                    if (bitEnd) begin
                        state    <= UartData;
                        bitIndex <= '0;
                        txd      <= shiftReg[0];
                    end
                end
                UartData: begin
                    if (bitEnd) begin
                        bitIndex <= bitIndex + 1'b1;
                        if (bitIndex == 3'd7) begin
                            state <= UartStop;
                            txd   <= 1'b1;
                        end else begin
                            txd <= shiftReg[1];
                        end
                    end
                end
                UartStop: begin
                    // Line already high, just wait out the stop bit
                    if (bitEnd) begin
                        state <= UartIdle;
                    end
                end
                default: state <= UartIdle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == UartIdle && txStart) begin
            shiftReg <= txByte;
        end else if (state == UartData && bitEnd) begin
            shiftReg <= shiftReg >> 1;
        end
    end

endmodule

//--- sha256Compressor.sv
`include "miner_settings.svh"

module sha256Compressor import miner_pkg::*; (
    input  logic         clock,
    input  logic         rstN,
    input  logic         compressStart,
    input  logic [511:0] blockIn,
    input  logic [255:0] chainIn,
    output logic [255:0] digest,
    output logic         compressDone
);

    // Counts 0..SHA_ROUNDS, the extra step adds the chaining value
    logic [6:0]  roundIndex;
    logic        active;
    logic        loadStep;
    logic        roundStep;
    logic        finalStep;
    logic [31:0] a, b, c, d, e, f, g, h;
    // Rolling window, W[t] always sits in word 0
    logic [31:0] schedule [16];
    logic [31:0] t1;
    logic [31:0] t2;
    logic [31:0] nextWord;

    function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
        return (x >> n) | (x << (32 - n));
    endfunction

    function automatic logic [31:0] bigSigma0(input logic [31:0] x);
        return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
    endfunction

    function automatic logic [31:0] bigSigma1(input logic [31:0] x);
        return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
    endfunction

    function automatic logic [31:0] smallSigma0(input logic [31:0] x);
        return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
    endfunction

    function automatic logic [31:0] smallSigma1(input logic [31:0] x);
        return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
    endfunction

    assign loadStep  = compressStart && !active;
    assign roundStep = active && roundIndex != 7'(`SHA_ROUNDS);
    assign finalStep = active && roundIndex == 7'(`SHA_ROUNDS);

    always_comb begin
        t1 = h + bigSigma1(e) + ((e & f) ^ (~e & g))
            + roundConstant(roundIndex[5:0]) + schedule[0];
        t2 = bigSigma0(a) + ((a & b) ^ (a & c) ^ (b & c));
        // W[t+16] from the current window
        nextWord = smallSigma1(schedule[14]) + schedule[9]
            + smallSigma0(schedule[1]) + schedule[0];
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            active       <= 1'b0;
            roundIndex   <= '0;
            compressDone <= 1'b0;
        end else begin
            compressDone <= finalStep;
            if (loadStep) begin
                active     <= 1'b1;
                roundIndex <= '0;
            end else if (roundStep) begin
                roundIndex <= roundIndex + 7'd1;
            end else if (finalStep) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (loadStep) begin
            {a, b, c, d, e, f, g, h} <= chainIn;
            for (int i = 0; i < 16; i++) begin
                schedule[i] <= blockIn[511 - 32 * i -: 32];
            end
        end else if (roundStep) begin
            a <= t1 + t2;
            b <= a;
            c <= b;
            d <= c;
            e <= d + t1;
            f <= e;
            g <= f;
            h <= g;
            for (int i = 0; i < 15; i++) begin
                schedule[i] <= schedule[i + 1];
            end
            schedule[15] <= nextWord;
        end else if (finalStep) begin
            // Word-wise add, held until the next compression ends
            digest <= {
                chainIn[255:224] + a,
                chainIn[223:192] + b,
                chainIn[191:160] + c,
                chainIn[159:128] + d,
                chainIn[127:96] + e,
                chainIn[95:64] + f,
                chainIn[63:32] + g,
                chainIn[31:0] + h
            };
        end
    end

endmodule

//--- minerControl.sv
`include "miner_settings.svh"

module minerControl import miner_pkg::*; (
    input  logic         clock,
    input  logic         rstN,
    input  logic [7:0]   rxByte,
    input  logic         rxValid,
    input  logic [8:0]   zeroBits,
    input  logic [255:0] digest,
    input  logic         compressDone,
    input  logic         txBusy,
    output logic         compressStart,
    output logic [511:0] blockIn,
    output logic [255:0] chainIn,
    output logic         txStart,
    output logic [7:0]   txByte,
    output logic         found,
    output logic [31:0]  foundNonce,
    output logic         searching
);

    minerState    state;
    logic [6:0]   byteCount;
    // Byte 0 ends up in the top byte after 80 shifts
    logic [639:0] header;
    logic [255:0] midstate;
    logic [31:0]  nonce;
    logic         hit;
    logic [2:0]   sendCount;
    logic [8:0]   leadingZeros;

    function automatic logic [8:0] countLeadingZeros(input logic [255:0] value);
        logic [8:0] count;
        logic       seenOne;
        count   = '0;
        seenOne = 1'b0;
        for (int i = 255; i >= 0; i--) begin
            if (value[i]) begin
                seenOne = 1'b1;
            end else if (!seenOne) begin
                count = count + 9'd1;
            end
        end
        return count;
    endfunction

    assign leadingZeros = countLeadingZeros(digest);
    assign searching = state == Block1 || state == Block2 || state == Check;

    // Block1 is bytes 0..63, Block2 the tail, nonce and padding for 640 bits
    assign blockIn = (state == Block1) ? header[639:128]
        : {header[127:32], nonce, 8'h80, 312'd0, 64'd640};
    assign chainIn = (state == Block1) ? initialHash : midstate;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            state         <= Load;
            byteCount     <= '0;
            nonce         <= '0;
            hit           <= 1'b0;
            sendCount     <= '0;
            compressStart <= 1'b0;
            txStart       <= 1'b0;
            txByte        <= '0;
            found         <= 1'b0;
            foundNonce    <= '0;
        end else begin
            compressStart <= 1'b0;
            txStart       <= 1'b0;
            found         <= 1'b0;
            if (rxValid && state != Load) begin
                // New byte outside Load aborts and becomes byte 0
                state     <= Load;
                byteCount <= 7'd1;
            end else begin
                case (state)
                    Load: begin
                        if (rxValid) begin
                            byteCount <= byteCount + 7'd1;
                            if (byteCount == 7'(`HEADER_BYTES - 1)) begin
                                byteCount     <= '0;
                                nonce         <= {header[23:0], rxByte};
                                compressStart <= 1'b1;
                                state         <= Block1;
                            end
                        end
                    end
                    Block1: begin
                        if (compressDone) begin
                            compressStart <= 1'b1;
                            state         <= Block2;
                        end
                    end
                    Block2: begin
                        if (compressDone) begin
                            hit   <= leadingZeros >= zeroBits;
                            state <= Check;
                            // Next nonce starts now so Check overlaps its load
                            if (leadingZeros < zeroBits) begin
                                nonce         <= nonce + 32'd1;
                                compressStart <= 1'b1;
                            end
                        end
                    end
                    Check: begin
                        if (hit) begin
                            found      <= 1'b1;
                            foundNonce <= nonce;
                            sendCount  <= '0;
                            state      <= Send;
                        end else begin
                            state <= Block2;
                        end
                    end
                    Send: begin
                        // Strobe cycle and busy both mean a byte in flight
                        if (!txStart && !txBusy) begin
                            if (sendCount == 3'd4) begin
                                state <= Idle;
                            end else begin
                                txStart   <= 1'b1;
                                txByte    <= foundNonce[8 * (3 - sendCount[1:0]) +: 8];
                                sendCount <= sendCount + 3'd1;
                            end
                        end
                    end
                    default: state <= Idle;
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rxValid) begin
            header <= {header[631:0], rxByte};
        end
        if (state == Block1 && compressDone) begin
            midstate <= digest;
        end
    end

endmodule

//--- nonceMinerTop.sv
module nonceMinerTop (
    input  logic        clock,
    input  logic        rstN,
    input  logic        rxd,
    input  logic [8:0]  zeroBits,
    output logic        txd,
    output logic        found,
    output logic        searching,
    output logic [31:0] foundNonce
);

    logic [7:0]   rxByte;
    logic         rxValid;
    logic         compressStart;
    logic [511:0] blockIn;
    logic [255:0] chainIn;
    logic [255:0] digest;
    logic         compressDone;
    logic         txStart;
    logic [7:0]   txByte;
    logic         txBusy;

    uartReceiver receiver (
        .clock   (clock),
        .rstN    (rstN),
        .rxd     (rxd),
        .rxByte  (rxByte),
        .rxValid (rxValid)
    );

    minerControl control (
        .clock         (clock),
        .rstN          (rstN),
        .rxByte        (rxByte),
        .rxValid       (rxValid),
        .zeroBits      (zeroBits),
        .digest        (digest),
        .compressDone  (compressDone),
        .txBusy        (txBusy),
        .compressStart (compressStart),
        .blockIn       (blockIn),
        .chainIn       (chainIn),
        .txStart       (txStart),
        .txByte        (txByte),
        .found         (found),
        .foundNonce    (foundNonce),
        .searching     (searching)
    );

    sha256Compressor compressor (
        .clock         (clock),
        .rstN          (rstN),
        .compressStart (compressStart),
        .blockIn       (blockIn),
        .chainIn       (chainIn),
        .digest        (digest),
        .compressDone  (compressDone)
    );

    uartTransmitter transmitter (
        .clock   (clock),
        .rstN    (rstN),
        .txStart (txStart),
        .txByte  (txByte),
        .txd     (txd),
        .txBusy  (txBusy)
    );

endmodule

//--- nonceMiner_assertions.sv
`include "miner_settings.svh"

module nonceMiner_assertions (
    input logic clock,
    input logic rstN,
    input logic rxValid,
    input logic found,
    input logic txStart,
    input logic searching
);
    timeunit 1ns;
    timeprecision 1ps;

    // Raised by the testbench checks
    logic valueWrong;
    logic timingWrong;
    logic serialWrong;
    logic abortWrong;

    // Header bytes since reset or the last abort
    logic [6:0] strobeCount;
    // Sticky once the first full header is in
    logic       firstLoadDone;
    logic       ruleBroken;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            strobeCount   <= '0;
            firstLoadDone <= 1'b0;
        end else if (rxValid) begin
            // A byte after a full header aborts and counts as byte 0
            if (strobeCount == 7'(`HEADER_BYTES)) begin
                strobeCount <= 7'd1;
            end else begin
                strobeCount <= strobeCount + 7'd1;
            end
            if (strobeCount == 7'(`HEADER_BYTES - 1)) begin
                firstLoadDone <= 1'b1;
            end
        end
    end

    // Same rules as the two protocol properties, seen half a cycle early
    assign ruleBroken = (!firstLoadDone && (found || txStart))
        || (rstN && searching && strobeCount != 7'(`HEADER_BYTES));

    // No result activity in reset or before the first header is complete
    quietUntilLoaded: assert property (@(posedge clock) !firstLoadDone |-> !found && !txStart)
        else $error("found or txStart high before the first header was loaded");

    searchAfterHeader: assert property (@(posedge clock) disable iff (!rstN)
        searching |-> strobeCount == 7'(`HEADER_BYTES))
        else $error("searching high with only %0d header bytes received", strobeCount);

    nonceValue: assert property (@(posedge clock) !valueWrong)
        else $error("result value differs from the reference model");

    foundTiming: assert property (@(posedge clock) !timingWrong)
        else $error("found pulse arrived at the wrong cycle");

    serialBytes: assert property (@(posedge clock) !serialWrong)
        else $error("serial output differs from the latched nonce");

    abortBehavior: assert property (@(posedge clock) !abortWrong)
        else $error("search did not stop cleanly on a new byte");

endmodule

//--- tb_nonceMiner.sv
`include "miner_settings.svh"

module tb_nonceMiner import miner_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int valueFlag = 0;
    localparam int timingFlag = 1;
    localparam int serialFlag = 2;
    localparam int abortFlag = 3;
    // Start issue, two compressions, Check, then the found register
    localparam int foundLatency = 2 * (`SHA_ROUNDS + 2) + 4;
    localparam int cyclesPerNonce = `SHA_ROUNDS + 3;
    localparam int byteCycles = 10 * `CLOCKS_PER_BIT;

    localparam logic [31:0] kTable [64] = '{
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
        32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
        32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
        32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
        32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
        32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
        32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
        32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
        32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
        32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
        32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
    };

    logic        clock;
    logic        rstN;
    logic        rxd;
    logic [8:0]  zeroBits;
    logic        txd;
    logic        found;
    logic        searching;
    logic [31:0] foundNonce;

    logic [639:0] headers [4];
    logic [8:0]   sinkBytes [$];
    int           cycleCount = 0;
    int           lastStrobeCycle = 0;
    int           foundCycle = 0;
    int           foundCount = 0;
    int           watchdogCycles = 0;

    nonceMinerTop DUT (
        .clock      (clock),
        .rstN       (rstN),
        .rxd        (rxd),
        .zeroBits   (zeroBits),
        .txd        (txd),
        .found      (found),
        .searching  (searching),
        .foundNonce (foundNonce)
    );

    bind nonceMinerTop nonceMiner_assertions checks (
        .clock     (clock),
        .rstN      (rstN),
        .rxValid   (rxValid),
        .found     (found),
        .txStart   (txStart),
        .searching (searching)
    );

    function automatic logic [31:0] ror(input logic [31:0] x, input int n);
        return 32'({x, x} >> n);
    endfunction

    // Reference SHA-256 compression of one 512-bit block
    function automatic logic [255:0] compressModel(input logic [255:0] chain,
                                                   input logic [511:0] block);
        logic [31:0]  w [64];
        logic [31:0]  v [8];
        logic [31:0]  s0;
        logic [31:0]  s1;
        logic [31:0]  t1;
        logic [31:0]  t2;
        logic [255:0] result;
        for (int t = 0; t < 16; t++) begin
            w[t] = block[511 - 32 * t -: 32];
        end
        for (int t = 16; t < 64; t++) begin
            s0 = ror(w[t - 15], 7) ^ ror(w[t - 15], 18) ^ (w[t - 15] >> 3);
            s1 = ror(w[t - 2], 17) ^ ror(w[t - 2], 19) ^ (w[t - 2] >> 10);
            w[t] = w[t - 16] + s0 + w[t - 7] + s1;
        end
        for (int i = 0; i < 8; i++) begin
            v[i] = chain[255 - 32 * i -: 32];
        end
        for (int t = 0; t < 64; t++) begin
            s1 = ror(v[4], 6) ^ ror(v[4], 11) ^ ror(v[4], 25);
            t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + kTable[t] + w[t];
            s0 = ror(v[0], 2) ^ ror(v[0], 13) ^ ror(v[0], 22);
            t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
            for (int i = 7; i > 0; i--) begin
                v[i] = v[i - 1];
            end
            v[4] = v[4] + t1;
            v[0] = t1 + t2;
        end
        for (int i = 0; i < 8; i++) begin
            result[255 - 32 * i -: 32] = chain[255 - 32 * i -: 32] + v[i];
        end
        return result;
    endfunction

    function automatic bit leadingClear(input logic [255:0] value, input int zeros);
        for (int i = 0; i < zeros; i++) begin
            if (value[255 - i]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // First nonce from word 19 upward whose digest meets the difficulty
    function automatic logic [31:0] firstNonce(input logic [639:0] hdr, input int zeros,
                                               output int tries);
        logic [255:0] mid;
        logic [255:0] dig;
        logic [31:0]  nonce;
        mid = compressModel(initialHash, hdr[639:128]);
        nonce = hdr[31:0];
        tries = 0;
        while (tries < (1 << 20)) begin
            tries++;
            // 80-byte message, a single one bit, zeros, then the length 640
            dig = compressModel(mid, {hdr[127:32], nonce, 1'b1, 319'd0, 64'd640});
            if (leadingClear(dig, zeros)) begin
                return nonce;
            end
            nonce = nonce + 32'd1;
        end
        return nonce;
    endfunction

    task automatic stopOnFailure();
        $display("Test failed");
        // Let the bound assertion see the flag first
        @(posedge clock);
        #1;
        $fatal(1, "Run stopped by a failed check");
    endtask

    task automatic raiseFlag(input int which);
        case (which)
            valueFlag: DUT.checks.valueWrong = 1'b1;
            timingFlag: DUT.checks.timingWrong = 1'b1;
            serialFlag: DUT.checks.serialWrong = 1'b1;
            default: DUT.checks.abortWrong = 1'b1;
        endcase
    endtask

    task automatic reportFailure(input string what, input int which);
        $display("%s", what);
        raiseFlag(which);
        stopOnFailure();
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected, input int which);
        if (got !== expected) begin
            $display("Mismatch %s: got %h expected %h", name, got, expected);
            raiseFlag(which);
            stopOnFailure();
        end
    endtask

    task automatic holdBit(input logic value);
        @(posedge clock);
        #5;
        rxd = value;
        repeat (`CLOCKS_PER_BIT - 1) @(posedge clock);
    endtask

    // 8N1, LSB first
    task automatic sendByte(input logic [7:0] value);
        holdBit(1'b0);
        for (int i = 0; i < 8; i++) begin
            holdBit(value[i]);
        end
        holdBit(1'b1);
    endtask

    task automatic sendHeader(input logic [639:0] hdr, input int first);
        for (int i = first; i < `HEADER_BYTES; i++) begin
            sendByte(hdr[639 - 8 * i -: 8]);
        end
    endtask

    // Waits for found, then the four result bytes on txd
    task automatic collectResult(input logic [31:0] expected, input bit timed);
        int          startCount;
        logic [8:0]  entry;
        startCount = foundCount;
        while (foundCount == startCount) begin
            @(negedge clock);
        end
        if (timed && foundCycle - lastStrobeCycle != foundLatency) begin
            reportFailure($sformatf("found came %0d cycles after the last byte, not %0d",
                foundCycle - lastStrobeCycle, foundLatency), timingFlag);
        end
        checkValue("foundNonce", foundNonce, expected, valueFlag);
        while (sinkBytes.size() < 4) begin
            @(negedge clock);
        end
        for (int i = 0; i < 4; i++) begin
            entry = sinkBytes.pop_front();
            if (!entry[8]) begin
                reportFailure("Stop bit on txd was low", serialFlag);
            end
            checkValue($sformatf("txd byte %0d", i), {24'd0, entry[7:0]},
                {24'd0, expected[31 - 8 * i -: 8]}, serialFlag);
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
    end

    // Stable mid-cycle view of strobes and results
    always @(negedge clock) begin
        if (DUT.rxValid === 1'b1) begin
            lastStrobeCycle = cycleCount;
        end
        if (found === 1'b1) begin
            foundCount++;
            foundCycle = cycleCount;
        end
    end

    always @(negedge clock) begin
        if (DUT.checks.ruleBroken === 1'b1) begin
            $display("found, txStart or searching rose outside the allowed window");
            stopOnFailure();
        end
    end

    // Serial sink, samples mid-bit on falling clock edges
    always begin : serialSink
        logic [7:0] value;
        @(negedge txd);
        repeat (`CLOCKS_PER_BIT / 2) @(negedge clock);
        for (int i = 0; i < 8; i++) begin
            repeat (`CLOCKS_PER_BIT) @(negedge clock);
            value[i] = txd;
        end
        repeat (`CLOCKS_PER_BIT) @(negedge clock);
        sinkBytes.push_back({txd, value});
    end

    initial begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge clock);
        $display("Watchdog expired before all results arrived");
        $display("Test failed");
        $fatal(1, "Simulation timed out");
    end

    initial begin
        integer      seed;
        int          triesB;
        int          triesD;
        int          abortCount;
        logic [31:0] expectedB;
        logic [31:0] expectedD;
        rxd = 1'b1;
        rstN = 1'b1;
        zeroBits = 9'd0;
        DUT.checks.valueWrong = 1'b0;
        DUT.checks.timingWrong = 1'b0;
        DUT.checks.serialWrong = 1'b0;
        DUT.checks.abortWrong = 1'b0;
        seed = 98;
        for (int h = 0; h < 4; h++) begin
            for (int w = 0; w < `HEADER_BYTES / 4; w++) begin
                headers[h][639 - 32 * w -: 32] = $random(seed);
            end
        end
        expectedB = firstNonce(headers[1], 6, triesB);
        expectedD = firstNonce(headers[3], 6, triesD);
        // Predicted nonces, four headers plus result bytes on the line, slack
        watchdogCycles = (triesB + triesD + 2) * cyclesPerNonce + 4 * foundLatency
            + (4 * `HEADER_BYTES + 12) * byteCycles + 5000;
        #1 rstN = 1'b0;
        repeat (8) @(posedge clock);
        #5 rstN = 1'b1;
        @(negedge clock);
        checkValue("txd", {31'd0, txd}, 32'd1, serialFlag);

        // Zero difficulty, the starting nonce wins
        sendHeader(headers[0], 0);
        collectResult(headers[0][31:0], 1'b1);

        @(posedge clock);
        #5 zeroBits = 9'd6;
        sendHeader(headers[1], 0);
        collectResult(expectedB, 1'b0);

        // Abort mid-search, the abort byte opens the next header
        sendHeader(headers[2], 0);
        while (!searching) begin
            @(negedge clock);
        end
        abortCount = foundCount;
        sendByte(headers[3][639:632]);
        // Abort lands the cycle after the byte strobe
        @(negedge clock);
        while (DUT.rxValid !== 1'b1) begin
            @(negedge clock);
        end
        @(negedge clock);
        if (searching !== 1'b0) begin
            reportFailure("searching stayed high after a byte arrived mid-search", abortFlag);
        end
        sendHeader(headers[3], 1);
        if (foundCount != abortCount) begin
            reportFailure("found pulsed for the aborted header", abortFlag);
        end
        collectResult(expectedD, 1'b0);

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- tb.f
+incdir+.
miner_pkg.sv
uartReceiver.sv
uartTransmitter.sv
sha256Compressor.sv
minerControl.sv
nonceMinerTop.sv
nonceMiner_assertions.sv
tb_nonceMiner.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_nonceMiner
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS ?= --binary --timing --assert --timescale $(TIMESCALE)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
